//--- dv/decode_stage_assert.sv
`timescale 1ns/1ps

module decode_stage_assert (
  input logic             i_clk,
  input logic             i_rst_n,
  input logic             i_stall,
  input logic             o_take_branch,
  input mips_pkg::if_id_t if_id_q,   // IF/ID register inside the top level
  input mips_pkg::id_ex_t o_id_ex
);

  // A branch decides only for a valid, non-stalled instruction
  a_take_valid : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_take_branch |-> (if_id_q.valid && !i_stall)) else $error("take without valid");

  a_bubble_ctrl : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !o_id_ex.valid |-> (o_id_ex.ctrl == '0)) else $error("bubble carries control");

  a_rst_take : assert property (@(posedge i_clk)
    !i_rst_n |-> !o_take_branch) else $error("take during reset");

endmodule

bind decode_stage decode_stage_assert u_assert (.*);

//--- dv/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
  import mips_pkg::*;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] npc;
    wb_t         wb;
    fwd_t        fwd;
    logic        stall;
    logic        take;      // Expected decision in the non-stalled cycle
    logic [31:0] tgt;
  } row_t;

  localparam logic [31:0] NPC = 32'h4000_1004;
  localparam wb_t  NO_WB  = '0;
  localparam fwd_t NO_FWD = '0;

  logic i_clk = 1'b0;
  logic i_rst_n = 1'b0;
  if_id_t i_if = '0;
  wb_t i_wb = '0;
  fwd_t i_fwd = '0;
  logic i_stall = 1'b0;
  id_ex_t o_id_ex;
  logic o_take_branch;
  logic [31:0] o_branch_target;
  logic [31:0] shadow [32];   // Register file model fed from the write-back stimulus
  integer seed = 32'h779c;
  row_t rows[$];

  decode_stage #(.p_data_w(32)) uut (.*);

  always #4 i_clk = ~i_clk;

  // ---------------------------------------------------------------------
  // Encoders and reference decoder
  // ---------------------------------------------------------------------
  function automatic logic [31:0] rtype(int rs, int rt, int rd, logic [5:0] fn);
    return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction
  function automatic logic [31:0] itype(logic [5:0] op, int rs, int rt, logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction
  function automatic logic [31:0] jtype(logic [5:0] op, logic [25:0] t);
    return {op, t};
  endfunction

  function automatic ctrl_t ref_ctrl(logic [5:0] op, logic [5:0] fn);
    ctrl_t c;
    c = '0;
    case (op)
      OP_RTYPE: begin
        if (fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT}) begin
          c.reg_dst = 1'b1;
          c.reg_write = 1'b1;   // ALU_FUNCT is the zero code
        end else if (fn == FN_JALR) begin
          c.reg_write = 1'b1;
          c.is_jal = 1'b1;
        end
      end
      OP_ADDI, OP_ANDI, OP_ORI, OP_SLTI, OP_LUI, OP_LW: begin
        c.alu_src = 1'b1;
        c.reg_write = 1'b1;
        c.alu_op = (op == OP_ANDI) ? ALU_AND : (op == OP_ORI) ? ALU_OR :
                   (op == OP_SLTI) ? ALU_SLT : (op == OP_LUI) ? ALU_LUI : ALU_ADD;
        c.mem_read = (op == OP_LW);
        c.mem_to_reg = (op == OP_LW);
      end
      OP_SW: begin
        c.alu_src = 1'b1;
        c.alu_op = ALU_ADD;
        c.mem_write = 1'b1;
      end
      OP_BEQ, OP_BNE: c.alu_op = ALU_SUB;
      OP_JAL: begin
        c.reg_write = 1'b1;
        c.is_jal = 1'b1;
      end
      default: ;                // Unknown opcode is a no-op
    endcase
    return c;
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic wait_valid(output int cycles);
    cycles = 0;
    while (!o_id_ex.valid) begin
      @(negedge i_clk);
      cycles++;
      if (cycles > 10) begin
        $display("Decoded output valid never arrived");
        $display("ERRORS FOUND");
        $fatal(1);
      end
    end
  endtask

  // ---------------------------------------------------------------------
  // Stimulus table
  // ---------------------------------------------------------------------
  initial begin
    rows.push_back('{rtype(1, 2, 3, FN_ADD), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{rtype(4, 5, 6, FN_SUB), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{rtype(7, 8, 9, FN_AND), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{rtype(10, 11, 12, FN_OR), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{rtype(13, 14, 15, FN_SLT), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{itype(OP_ADDI, 1, 2, 16'h0005), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{itype(OP_ADDI, 3, 4, 16'hfffd), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{itype(OP_ANDI, 5, 6, 16'h00ff), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{itype(OP_ORI, 7, 8, 16'h8001), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{itype(OP_SLTI, 9, 10, 16'h7fff), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{itype(OP_LUI, 0, 11, 16'h1234), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{itype(OP_LW, 12, 13, 16'hfff0), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{itype(OP_SW, 14, 15, 16'h0010), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{itype(6'h3f, 1, 2, 16'h0004), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    rows.push_back('{itype(6'h1c, 3, 4, 16'h0004), NPC, NO_WB, NO_FWD, 1'b0, 1'b0, NPC});
    // Branch target is NPC + (imm << 2) whether taken or not
    rows.push_back('{itype(OP_BEQ, 4, 4, 16'h0004), NPC, NO_WB, NO_FWD, 1'b0, 1'b1,
                     32'h4000_1014});
    rows.push_back('{itype(OP_BEQ, 4, 5, 16'hfffe), NPC, NO_WB, '{1'b1, 1'b1, 32'd7, 32'd7},
                     1'b0, 1'b1, 32'h4000_0ffc});
    rows.push_back('{itype(OP_BEQ, 4, 5, 16'h0004), NPC, NO_WB, '{1'b1, 1'b1, 32'd1, 32'd2},
                     1'b0, 1'b0, 32'h4000_1014});
    rows.push_back('{itype(OP_BNE, 4, 5, 16'h0004), NPC, NO_WB, '{1'b1, 1'b1, 32'd1, 32'd2},
                     1'b0, 1'b1, 32'h4000_1014});
    rows.push_back('{itype(OP_BNE, 6, 6, 16'h0004), NPC, NO_WB, NO_FWD, 1'b0, 1'b0,
                     32'h4000_1014});
    // Jumps
    rows.push_back('{jtype(OP_J, 26'h100), NPC, NO_WB, NO_FWD, 1'b0, 1'b1, 32'h4000_0400});
    rows.push_back('{jtype(OP_JAL, 26'h3_0001), NPC, NO_WB, NO_FWD, 1'b0, 1'b1, 32'h400c_0004});
    rows.push_back('{rtype(7, 0, 0, FN_JR), NPC, NO_WB, '{1'b1, 1'b0, 32'h2000, 32'd0},
                     1'b0, 1'b1, 32'h2000});
    rows.push_back('{rtype(8, 0, 31, FN_JALR), NPC, NO_WB, '{1'b1, 1'b0, 32'h3000, 32'd0},
                     1'b0, 1'b1, 32'h3000});
    // Register file edges and stall
    rows.push_back('{rtype(0, 3, 1, FN_ADD), NPC, '{1'b1, 5'd0, 32'hdead}, NO_FWD,
                     1'b0, 1'b0, NPC});
    rows.push_back('{rtype(9, 10, 2, FN_ADD), NPC, '{1'b1, 5'd9, 32'hcafe_0009}, NO_FWD,
                     1'b0, 1'b0, NPC});
    // Stalled beq that would be taken decides only after release
    rows.push_back('{itype(OP_BEQ, 4, 4, 16'h0004), NPC, NO_WB, NO_FWD, 1'b1, 1'b1,
                     32'h4000_1014});
  end

  initial begin
    row_t        r;
    ctrl_t       e;
    logic [31:0] v;
    logic [31:0] rd1;
    logic [31:0] rd2;
    int          late;
    for (int k = 0; k < 32; k++) shadow[k] = '0;
    repeat (16) @(negedge i_clk);
    i_rst_n = 1'b1;
    check("o_take_branch", 32'(o_take_branch), 32'd0);
    check("o_id_ex.valid", 32'(o_id_ex.valid), 32'd0);
    // Fill registers 1..31 through the write-back port
    for (int k = 1; k < 32; k++) begin
      v = $random(seed);
      i_wb = '{1'b1, 5'(k), v};
      shadow[k] = v;
      @(negedge i_clk);
    end
    i_wb = NO_WB;
    foreach (rows[n]) begin
      r = rows[n];
      i_if = '{1'b1, r.npc, r.instr};
      @(negedge i_clk);
      // Instruction now in ID with a no-op follower waiting on i_if
      i_if = '{1'b1, r.npc + 32'd4, 32'hfc00_0000};
      i_wb = r.wb;
      i_fwd = r.fwd;
      i_stall = r.stall;
      if (r.wb.reg_write && r.wb.write_register != 5'd0)
        shadow[r.wb.write_register] = r.wb.write_data;
      #1;
      check("o_take_branch", 32'(o_take_branch), 32'(r.take && !r.stall));
      if (!r.stall) check("o_branch_target", o_branch_target, r.tgt);
      @(negedge i_clk);
      if (r.stall) begin
        check("o_id_ex.valid", 32'(o_id_ex.valid), 32'd0);
        i_stall = 1'b0;
        #1;
        // Held instruction decides in its release cycle
        check("o_take_branch", 32'(o_take_branch), 32'(r.take));
        check("o_branch_target", o_branch_target, r.tgt);
        @(negedge i_clk);
      end
      wait_valid(late);
      check("o_id_ex.valid wait cycles", 32'(late), 32'd0);
      e = ref_ctrl(r.instr[31:26], r.instr[5:0]);
      rd1 = e.is_jal ? r.npc : r.fwd.use_a ? r.fwd.value_a : shadow[r.instr[25:21]];
      rd2 = r.fwd.use_b ? r.fwd.value_b : shadow[r.instr[20:16]];
      check("o_id_ex.ctrl", 32'(o_id_ex.ctrl), 32'(e));
      check("o_id_ex.read_data_1", o_id_ex.read_data_1, rd1);
      check("o_id_ex.read_data_2", o_id_ex.read_data_2, rd2);
      check("o_id_ex.sign_ext_imm", o_id_ex.sign_ext_imm,
            {{16{r.instr[15]}}, r.instr[15:0]});
      check("o_id_ex.rs", 32'(o_id_ex.rs), 32'(r.instr[25:21]));
      check("o_id_ex.rt", 32'(o_id_ex.rt), 32'(r.instr[20:16]));
      check("o_id_ex.rd", 32'(o_id_ex.rd),
            (r.instr[31:26] == OP_JAL) ? 32'd31 : 32'(r.instr[15:11]));
      check("o_id_ex.shamt", 32'(o_id_ex.shamt), 32'(r.instr[10:6]));
      check("o_id_ex.funct", 32'(o_id_ex.funct), 32'(r.instr[5:0]));
      check("o_id_ex.opcode", 32'(o_id_ex.opcode), 32'(r.instr[31:26]));
      i_if = '0;
      i_wb = NO_WB;
      i_fwd = NO_FWD;
      @(negedge i_clk);
      // Follower is flushed by a taken branch or decoded once
      check("o_id_ex.valid", 32'(o_id_ex.valid), 32'(!r.take));
      if (o_id_ex.valid) check("o_id_ex.opcode", 32'(o_id_ex.opcode), 32'h3f);
      @(negedge i_clk);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit #(
  parameter int p_data_w = mips_pkg::DATA_W
) (
  input  mips_pkg::branch_type_e i_branch_type,
  input  logic [p_data_w-1:0]    i_next_pc,       // PC+4 of the branch
  input  logic [p_data_w-1:0]    i_sign_ext_imm,
  input  logic [25:0]            i_target,        // J-type target field
  input  logic [p_data_w-1:0]    i_op_a,          // rs after forwarding
  input  logic [p_data_w-1:0]    i_op_b,          // rt after forwarding
  input  logic                   i_enable,        // Valid and not stalled
  output logic                   o_take_branch,
  output logic [p_data_w-1:0]    o_branch_target
);

  import mips_pkg::*;

  logic [p_data_w-1:0] br_target;   // Relative branch
  logic [p_data_w-1:0] jmp_target;  // Region jump
  logic                is_equal;
  logic                cond;

  assign br_target  = i_next_pc + (i_sign_ext_imm << 2);
  assign jmp_target = {i_next_pc[p_data_w-1 -: 4], i_target, 2'b00};
  assign is_equal   = (i_op_a == i_op_b);

  always_comb begin
    cond = 1'b0;
    o_branch_target = i_next_pc;              // Fall through by default
    case (i_branch_type)
      BR_BEQ: begin
        cond = is_equal;
        o_branch_target = br_target;
      end
      BR_BNE: begin
        cond = !is_equal;
        o_branch_target = br_target;
      end
      BR_J, BR_JAL: begin
        cond = 1'b1;
        o_branch_target = jmp_target;
      end
      BR_JR, BR_JALR: begin
        cond = 1'b1;
        o_branch_target = i_op_a;             // Register target
      end
      default: ;
    endcase
  end

  assign o_take_branch = i_enable && cond;

endmodule

//--- hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
  input  logic [5:0]             i_opcode,
  input  logic [5:0]             i_funct,         // Looked at under OP_RTYPE only
  output mips_pkg::ctrl_t        o_ctrl,
  output mips_pkg::branch_type_e o_branch_type
);

  import mips_pkg::*;

  // ----------------------------------------------------------------------
  // Main decoder with all zeros for unknown codes
  // ----------------------------------------------------------------------
  always_comb begin
    o_ctrl        = '0;
    o_branch_type = BR_NONE;
    case (i_opcode)
      OP_RTYPE: begin
        case (i_funct)
          FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: begin
            o_ctrl.reg_dst   = 1'b1;          // Result to rd
            o_ctrl.reg_write = 1'b1;
            o_ctrl.alu_op    = ALU_FUNCT;     // EX picks the op from funct
          end
          FN_JR: o_branch_type = BR_JR;       // No write
          FN_JALR: begin
            o_ctrl.reg_write = 1'b1;
            o_ctrl.is_jal    = 1'b1;          // Link value replaces operand A
            o_branch_type    = BR_JALR;
          end
          default: ;
        endcase
      end
      OP_ADDI, OP_ANDI, OP_ORI, OP_SLTI, OP_LUI: begin
        o_ctrl.alu_src   = 1'b1;              // Immediate as operand B
        o_ctrl.reg_write = 1'b1;              // Result to rt
        case (i_opcode)
          OP_ANDI: o_ctrl.alu_op = ALU_AND;
          OP_ORI:  o_ctrl.alu_op = ALU_OR;
          OP_SLTI: o_ctrl.alu_op = ALU_SLT;
          OP_LUI:  o_ctrl.alu_op = ALU_LUI;
          default: o_ctrl.alu_op = ALU_ADD;   // addi
        endcase
      end
      OP_LW: begin
        o_ctrl.alu_src    = 1'b1;             // Address is rs + imm
        o_ctrl.alu_op     = ALU_ADD;
        o_ctrl.reg_write  = 1'b1;
        o_ctrl.mem_read   = 1'b1;
        o_ctrl.mem_to_reg = 1'b1;
      end
      OP_SW: begin
        o_ctrl.alu_src   = 1'b1;
        o_ctrl.alu_op    = ALU_ADD;
        o_ctrl.mem_write = 1'b1;              // rt is the store data
      end
      OP_BEQ: begin
        o_ctrl.alu_op = ALU_SUB;
        o_branch_type = BR_BEQ;
      end
      OP_BNE: begin
        o_ctrl.alu_op = ALU_SUB;
        o_branch_type = BR_BNE;
      end
      OP_J: o_branch_type = BR_J;
      OP_JAL: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.is_jal    = 1'b1;              // Links next_pc into $ra
        o_branch_type    = BR_JAL;
      end
      default: ;                              // No-op
    endcase
  end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter int p_data_w = mips_pkg::DATA_W
) (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  mips_pkg::if_id_t    i_if,             // Fetched instruction
  input  mips_pkg::wb_t       i_wb,             // Write-back request
  input  mips_pkg::fwd_t      i_fwd,            // Forwarding values and flags
  input  logic                i_stall,          // From hazard logic
  output mips_pkg::id_ex_t    o_id_ex,          // Decoded bundle to EX
  output logic                o_take_branch,
  output logic [p_data_w-1:0] o_branch_target
);

  import mips_pkg::*;

  // ----------------------------------------------------------------------
  // Pipeline wiring
  // ----------------------------------------------------------------------
  if_id_t if_id_q;   // IF/ID register output
  id_ex_t id_ex_d;   // Decode result, bubble already applied on stall

  // Stall holds the instruction, taken branch drops the wrong-path one
  pipe_reg #(.T(if_id_t)) u_if_id (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_hold  (i_stall),
    .i_bubble(o_take_branch),
    .i_d     (i_if),
    .o_q     (if_id_q)
  );

  id_stage #(.p_data_w(p_data_w)) u_id (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_if_id        (if_id_q),
    .i_wb           (i_wb),
    .i_fwd          (i_fwd),
    .i_stall        (i_stall),
    .o_id_ex        (id_ex_d),
    .o_take_branch  (o_take_branch),
    .o_branch_target(o_branch_target)
  );

  // Never held
  pipe_reg #(.T(id_ex_t)) u_id_ex (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_hold  (1'b0),
    .i_bubble(1'b0),
    .i_d     (id_ex_d),
    .o_q     (o_id_ex)
  );

endmodule

//--- hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage #(
  parameter int p_data_w = mips_pkg::DATA_W
) (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  mips_pkg::if_id_t    i_if_id,          // From IF/ID register
  input  mips_pkg::wb_t       i_wb,             // Write-back port
  input  mips_pkg::fwd_t      i_fwd,            // Forwarding values
  input  logic                i_stall,
  output mips_pkg::id_ex_t    o_id_ex,          // To ID/EX register
  output logic                o_take_branch,
  output logic [p_data_w-1:0] o_branch_target
);

  import mips_pkg::*;

  // ----------------------------------------------------------------------
  // Instruction fields
  // ----------------------------------------------------------------------
  logic [5:0]  opcode;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [4:0]  shamt;
  logic [5:0]  funct;
  logic [15:0] imm;
  logic [25:0] target;

  assign opcode = i_if_id.instruction[31:26];
  assign rs     = i_if_id.instruction[25:21];
  assign rt     = i_if_id.instruction[20:16];
  assign rd     = i_if_id.instruction[15:11];
  assign shamt  = i_if_id.instruction[10:6];
  assign funct  = i_if_id.instruction[5:0];
  assign imm    = i_if_id.instruction[15:0];
  assign target = i_if_id.instruction[25:0];

  logic [p_data_w-1:0] rs_data, rt_data;   // Raw register reads
  logic [p_data_w-1:0] op_a, op_b;         // After forwarding
  logic [p_data_w-1:0] sign_ext_imm;
  ctrl_t               ctrl;
  branch_type_e        br_type;
  logic                valid;              // Instruction advances this cycle

  registers_bank #(.p_data_w(p_data_w)) u_regs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_wb     (i_wb),
    .i_rs     (rs),
    .i_rt     (rt),
    .o_rs_data(rs_data),
    .o_rt_data(rt_data)
  );

  control_unit u_ctrl (
    .i_opcode     (opcode),
    .i_funct      (funct),
    .o_ctrl       (ctrl),
    .o_branch_type(br_type)
  );

  assign op_a = i_fwd.use_a ? i_fwd.value_a : rs_data;
  assign op_b = i_fwd.use_b ? i_fwd.value_b : rt_data;
  assign sign_ext_imm = {{(p_data_w-16){imm[15]}}, imm};
  assign valid = i_if_id.valid && !i_stall;

  // Compare and jump register use forwarded rs, never the link value
  branch_unit #(.p_data_w(p_data_w)) u_branch (
    .i_branch_type  (br_type),
    .i_next_pc      (i_if_id.next_pc),
    .i_sign_ext_imm (sign_ext_imm),
    .i_target       (target),
    .i_op_a         (op_a),
    .i_op_b         (op_b),
    .i_enable       (valid),
    .o_take_branch  (o_take_branch),
    .o_branch_target(o_branch_target)
  );

  // ----------------------------------------------------------------------
  // ID/EX bundle
  // ----------------------------------------------------------------------
  always_comb begin
    o_id_ex.valid        = valid;
    o_id_ex.ctrl         = valid ? ctrl : '0;  // Bubble carries no control
    o_id_ex.read_data_1  = ctrl.is_jal ? i_if_id.next_pc : op_a;  // Link value
    o_id_ex.read_data_2  = op_b;
    o_id_ex.sign_ext_imm = sign_ext_imm;
    o_id_ex.rs           = rs;
    o_id_ex.rt           = rt;
    o_id_ex.rd           = (br_type == BR_JAL) ? 5'd31 : rd;     // jal links to $ra
    o_id_ex.shamt        = shamt;
    o_id_ex.funct        = funct;
    o_id_ex.opcode       = opcode;
  end

endmodule

//--- hdl/mips_pkg.sv
package mips_pkg;

  // ----------------------------------------------------------------------
  // Widths and instruction encodings
  // ----------------------------------------------------------------------
  parameter int DATA_W = 32;                // Datapath width

  // Primary opcodes, instr[31:26]
  localparam logic [5:0] OP_RTYPE = 6'h00;  // Decoded further by funct
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_SLTI  = 6'h0a;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // Funct codes under OP_RTYPE, instr[5:0]
  localparam logic [5:0] FN_JR    = 6'h08;
  localparam logic [5:0] FN_JALR  = 6'h09;
  localparam logic [5:0] FN_ADD   = 6'h20;
  localparam logic [5:0] FN_SUB   = 6'h22;
  localparam logic [5:0] FN_AND   = 6'h24;
  localparam logic [5:0] FN_OR    = 6'h25;
  localparam logic [5:0] FN_SLT   = 6'h2a;

  // Jumps sit at or above BR_J so one compare catches them all
  typedef enum logic [2:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JAL, BR_JR, BR_JALR
  } branch_type_e;

  typedef enum logic [2:0] {
    ALU_FUNCT, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI
  } alu_op_e;

  // ----------------------------------------------------------------------
  // Payload structs
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic        alu_src;     // Immediate as ALU operand B
    alu_op_e     alu_op;
    logic        reg_dst;     // rd instead of rt as destination
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        mem_to_reg;  // Load data to write-back
    logic        is_jal;      // Link, write next_pc
  } ctrl_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] next_pc;      // PC+4 from fetch
    logic [31:0]       instruction;
  } if_id_t;

  typedef struct packed {
    logic              reg_write;
    logic [4:0]        write_register;
    logic [DATA_W-1:0] write_data;
  } wb_t;

  typedef struct packed {
    logic              use_a;    // Take value_a instead of rs read
    logic              use_b;    // Take value_b instead of rt read
    logic [DATA_W-1:0] value_a;
    logic [DATA_W-1:0] value_b;
  } fwd_t;

  typedef struct packed {
    logic              valid;
    ctrl_t             ctrl;
    logic [DATA_W-1:0] read_data_1;
    logic [DATA_W-1:0] read_data_2;
    logic [DATA_W-1:0] sign_ext_imm;
    logic [4:0]        rs;
    logic [4:0]        rt;
    logic [4:0]        rd;
    logic [4:0]        shamt;
    logic [5:0]        funct;
    logic [5:0]        opcode;
  } id_ex_t;

endpackage

//--- hdl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type T = logic
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_hold,    // Keep current content
  input  logic i_bubble,  // Load all zeros, clears valid and control
  input  T     i_d,
  output T     o_q
);

  // ----------------------------------------------------------------------
  // Hold has priority over bubble
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_q <= '0;
    end else if (i_hold) begin
      o_q <= o_q;
    end else if (i_bubble) begin
      o_q <= '0;
    end else begin
      o_q <= i_d;
    end
  end

endmodule

//--- hdl/registers_bank.sv
`timescale 1ns/1ps

module registers_bank #(
  parameter int p_data_w = mips_pkg::DATA_W
) (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  mips_pkg::wb_t       i_wb,        // Write-back request
  input  logic [4:0]          i_rs,
  input  logic [4:0]          i_rt,
  output logic [p_data_w-1:0] o_rs_data,
  output logic [p_data_w-1:0] o_rt_data
);

  import mips_pkg::*;

  logic [p_data_w-1:0] regs [32];
  logic                wr_en;              // Write to a register other than $0
  logic                hit_rs;
  logic                hit_rt;

  assign wr_en = i_wb.reg_write && (i_wb.write_register != 5'd0);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_wb.write_register] <= i_wb.write_data;
    end
  end

  // Same-cycle write bypasses the array
  assign hit_rs = wr_en && (i_wb.write_register == i_rs);
  assign hit_rt = wr_en && (i_wb.write_register == i_rt);

  assign o_rs_data = (i_rs == 5'd0) ? '0 : hit_rs ? i_wb.write_data : regs[i_rs];
  assign o_rt_data = (i_rt == 5'd0) ? '0 : hit_rt ? i_wb.write_data : regs[i_rt];

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module decode_stage_tb -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
grep -q "NO ERRORS" sim.log

//--- sources.f
hdl/mips_pkg.sv
hdl/registers_bank.sv
hdl/control_unit.sv
hdl/branch_unit.sv
hdl/pipe_reg.sv
hdl/id_stage.sv
hdl/decode_stage.sv
dv/decode_stage_assert.sv
dv/decode_stage_tb.sv
